// ==== tracker_top.f ====
hdl/tracker_pkg.sv
hdl/video_timing.sv
hdl/mask_threshold.sv
hdl/com_accumulator.sv
hdl/com_divider.sv
hdl/overlay_mixer.sv
hdl/tracker_top.sv
tests/tracker_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tracker_tb
FILELIST  ?= tracker_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tracker_tb.sv ====
`timescale 1ns/1ps

module tracker_tb;

  // 32x24 visible area with short blanking and 44 x 30 positions per frame
  localparam int H_ACT = 32;
  localparam int H_FP  = 4;
  localparam int H_SW  = 4;
  localparam int H_BP  = 4;
  localparam int V_ACT = 24;
  localparam int V_FP  = 2;
  localparam int V_SW  = 2;
  localparam int V_BP  = 2;
  localparam int H_TOT = H_ACT + H_FP + H_SW + H_BP;
  localparam int V_TOT = V_ACT + V_FP + V_SW + V_BP;
  localparam int FRAME_CYCLES   = H_TOT * V_TOT;
  localparam int RESET_CYCLES   = 8;
  localparam int N_FRAMES       = 5;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_FRAMES * FRAME_CYCLES + FRAME_CYCLES / 2;
  localparam int RECT_W = 9;
  localparam int RECT_H = 6;

  localparam int T_DELAY = 0;
  localparam int T_RESET = 1;
  localparam int T_TIMING = 2;
  localparam int T_RED = 3;
  localparam int T_GREEN = 4;
  localparam int T_BLUE = 5;
  localparam int T_COM = 6;
  localparam int T_EMPTY = 7;
  localparam int T_CROSS = 8;
  localparam int N_TESTS = 9;

  // one pixel as it entered the DUT plus what the output stage should do with it
  typedef struct packed {
    tracker_pkg::raster_t   raster;
    tracker_pkg::pixel565_t pixel;
    tracker_pkg::chan_e     chan;
    tracker_pkg::view_e     view;
    logic                   mask;   // expected threshold result
    logic                   locked;
    logic [10:0]            cx;
    logic [9:0]             cy;
  } stage_t;

  logic                   clk_pixel;
  logic                   sys_rst;
  tracker_pkg::pixel565_t pixel_in;
  tracker_pkg::chan_e     chan_sel;
  logic [3:0]             lower_nibble;
  logic [3:0]             upper_nibble;
  tracker_pkg::view_e     view_sel;
  tracker_pkg::raster_t   raster_src;
  tracker_pkg::raster_t   raster_out;
  tracker_pkg::rgb888_t   rgb_out;
  logic [10:0]            com_x;
  logic [9:0]             com_y;
  logic                   com_valid;

  integer      seed = 32'h897a474b;
  logic [31:0] noise;
  int          cyc = 0;
  int          frame_idx = 0;
  int          exp_h = 0;   // timing model position
  int          exp_v = 0;
  int          sx = 0;      // running sums of the expected mask
  int          sy = 0;
  int          cnt = 0;
  int          exp_x = 0;
  int          exp_y = 0;
  logic        pending = 1'b0; // a centre of mass is owed
  logic        tb_locked = 1'b0;
  logic [10:0] tb_cx = '0;
  logic [9:0]  tb_cy = '0;
  int          empty_seen = 0;
  int          cross_seen = 0;
  logic        run_over = 1'b0;
  logic        timed_out = 1'b0;
  stage_t      cur;
  stage_t      d1 = '0;     // one cycle back
  stage_t      d2 = '0;     // two cycles back to line up with raster_out
  logic [23:0] exp_rgb;
  int          rgb_id;
  int          checks [N_TESTS];
  int          errs [N_TESTS];
  logic [31:0] first_exp [N_TESTS];
  logic [31:0] first_got [N_TESTS];
  logic        first_is_value [N_TESTS];
  string       first_msg [N_TESTS];
  int          passed_tests = 0;
  int          failed_tests = 0;
  int          bad_checks = 0;

  tracker_top #(
    .H_ACTIVE(11'(H_ACT)), .H_FRONT(11'(H_FP)), .H_SYNC(11'(H_SW)), .H_BACK(11'(H_BP)),
    .V_ACTIVE(10'(V_ACT)), .V_FRONT(10'(V_FP)), .V_SYNC(10'(V_SW)), .V_BACK(10'(V_BP))
  ) tracker_top_inst (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst), .pixel_in(pixel_in), .chan_sel(chan_sel),
    .lower_nibble(lower_nibble), .upper_nibble(upper_nibble), .view_sel(view_sel),
    .raster_src(raster_src), .raster_out(raster_out), .rgb_out(rgb_out),
    .com_x(com_x), .com_y(com_y), .com_valid(com_valid)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #5 clk_pixel = ~clk_pixel;
  end

  function automatic string test_name(input int id);
    case (id)
      T_DELAY:  return "raster_delay";
      T_RESET:  return "reset_flags";
      T_TIMING: return "frame_timing";
      T_RED:    return "mask_red";
      T_GREEN:  return "mask_green";
      T_BLUE:   return "mask_blue";
      T_COM:    return "com_result";
      T_EMPTY:  return "empty_frame";
      default:  return "crosshair";
    endcase
  endfunction

  // expected raster at one position of the line and frame
  function automatic tracker_pkg::raster_t timing_at(input int h, input int v);
    tracker_pkg::raster_t r;
    r.hcount    = 11'(h);
    r.vcount    = 10'(v);
    r.hsync     = (h >= H_ACT + H_FP) && (h < H_ACT + H_FP + H_SW);
    r.vsync     = (v >= V_ACT + V_FP) && (v < V_ACT + V_FP + V_SW);
    r.active    = (h < H_ACT) && (v < V_ACT);
    r.new_frame = (h == H_ACT) && (v == V_ACT);
    return r;
  endfunction

  function automatic logic [23:0] widen(input tracker_pkg::pixel565_t p);
    return {p.red, 3'b000, p.green, 2'b00, p.blue, 3'b000};
  endfunction

  // inclusive window on the selected channel with each bound as its nibble then four zeros
  function automatic logic window_hit(input tracker_pkg::pixel565_t p,
                                      input tracker_pkg::chan_e c,
                                      input logic [3:0] lo, input logic [3:0] hi);
    logic [23:0] w;
    logic [7:0]  v;
    w = widen(p);
    case (c)
      tracker_pkg::CHAN_RED:   v = w[23:16];
      tracker_pkg::CHAN_GREEN: v = w[15:8];
      default:                 v = w[7:0];
    endcase
    return (v >= {lo, 4'h0}) && (v <= {hi, 4'h0});
  endfunction

  // rectangle that moves each frame on a dim noisy background
  function automatic tracker_pkg::pixel565_t make_pixel(input tracker_pkg::raster_t r,
                                                        input int frame,
                                                        input logic [31:0] rnd);
    tracker_pkg::pixel565_t p;
    int x0;
    int y0;
    x0 = 4 + 3 * frame;
    y0 = 3 + 2 * frame;
    if (!r.active) begin
      p = rnd[15:0]; // anything goes in blanking
    end else if (int'(r.hcount) >= x0 && int'(r.hcount) < x0 + RECT_W &&
                 int'(r.vcount) >= y0 && int'(r.vcount) < y0 + RECT_H) begin
      p.red   = 5'd29; // 0xe8
      p.green = 6'd40; // 0xa0 sits on the green upper bound
      p.blue  = 5'd8;  // 0x40 sits on the blue lower bound
    end else begin
      p.red   = {1'b0, rnd[3:0]}; // at most 0x78
      p.green = {1'b0, rnd[8:4]}; // at most 0x7c
      p.blue  = {2'b00, rnd[11:9]}; // at most 0x38
    end
    return p;
  endfunction

  function automatic logic on_cross(input stage_t s);
    return s.locked && ((s.raster.hcount == s.cx) || (s.raster.vcount == s.cy));
  endfunction

  function automatic logic [23:0] expected_rgb(input stage_t s, input tracker_pkg::view_e vw);
    if (!s.raster.active)
      return 24'h000000;
    else if (on_cross(s))
      return 24'hF2F2F2;
    else if (vw == tracker_pkg::VIEW_CAMERA)
      return widen(s.pixel);
    else
      return s.mask ? 24'hFFFFFF : 24'h000000;
  endfunction

  task automatic check(input int id, input logic [31:0] expected, input logic [31:0] actual);
    checks[id]++;
    assert (actual === expected) else begin
      if (errs[id] == 0) begin
        first_exp[id] = expected;
        first_got[id] = actual;
        first_is_value[id] = 1'b1;
      end
      errs[id]++;
      bad_checks++;
      $display("FAILED %s expected %h actual %h at cycle %0d", test_name(id), expected,
               actual, cyc);
    end
  endtask

  task automatic note_problem(input int id, input string msg);
    checks[id]++;
    assert (1'b0) else begin
      if (errs[id] == 0)
        first_msg[id] = msg;
      errs[id]++;
      bad_checks++;
      $display("test %s at cycle %0d: %s", test_name(id), cyc, msg);
    end
  endtask

  // frames 0 to 2 walk the channels in mask view then 3 has an empty window and 4 uses camera view
  task automatic apply_config(input int frame);
    view_sel = (frame >= 4) ? tracker_pkg::VIEW_CAMERA : tracker_pkg::VIEW_MASK;
    case (frame)
      1: begin
        chan_sel = tracker_pkg::CHAN_GREEN;
        lower_nibble = 4'h9;
        upper_nibble = 4'hA;
      end
      2: begin
        chan_sel = tracker_pkg::CHAN_BLUE;
        lower_nibble = 4'h4;
        upper_nibble = 4'h5;
      end
      3: begin
        chan_sel = tracker_pkg::CHAN_RED;
        lower_nibble = 4'hF; // only 0xf0 which nothing in the scene reaches
        upper_nibble = 4'hF;
      end
      default: begin
        chan_sel = tracker_pkg::CHAN_RED;
        lower_nibble = 4'hE;
        upper_nibble = 4'hF;
      end
    endcase
  endtask

  task automatic report_test(input int id);
    logic reached;
    reached = (checks[id] > 0);
    if (id == T_EMPTY)
      reached = (empty_seen > 0);
    if (id == T_CROSS)
      reached = reached && (cross_seen > 0);
    if (errs[id] == 0 && reached) begin
      passed_tests++;
      $display("test %s passed after %0d checks", test_name(id), checks[id]);
    end else begin
      failed_tests++;
      if (errs[id] == 0)
        $display("test %s failed because its stimulus never reached the check", test_name(id));
      else if (first_is_value[id])
        $display("FAILED %s expected %h actual %h, %0d errors", test_name(id), first_exp[id],
                 first_got[id], errs[id]);
      else
        $display("test %s failed: %s", test_name(id), first_msg[id]);
    end
  endtask

  // all driving and checking on the falling edge where DUT outputs are settled
  always @(negedge clk_pixel) begin
    if (!run_over) begin
      cyc = cyc + 1;
      sys_rst = (cyc < RESET_CYCLES);
      apply_config(frame_idx);
      noise = $random(seed);
      pixel_in = make_pixel(raster_src, frame_idx, noise);

      check((cyc <= RESET_CYCLES) ? T_RESET : T_TIMING, {7'b0, timing_at(exp_h, exp_v)},
            {7'b0, raster_src});
      if (sys_rst) begin
        exp_h = 0;
        exp_v = 0;
      end else if (exp_h == H_TOT - 1) begin
        exp_h = 0;
        exp_v = (exp_v == V_TOT - 1) ? 0 : exp_v + 1;
      end else begin
        exp_h = exp_h + 1;
      end

      if (com_valid) begin
        if (pending) begin
          check(T_COM, 32'(exp_x), 32'(com_x));
          check(T_COM, 32'(exp_y), 32'(com_y));
          pending = 1'b0;
          tb_locked = 1'b1;
          tb_cx = 11'(exp_x);
          tb_cy = 10'(exp_y);
        end else begin
          note_problem(T_EMPTY, "com_valid pulsed with no mask pixels in the last frame");
        end
      end else begin
        check(T_EMPTY, 32'(tb_cx), 32'(com_x)); // result holds between pulses
        check(T_EMPTY, 32'(tb_cy), 32'(com_y));
      end

      cur.raster = raster_src;
      cur.pixel  = pixel_in;
      cur.chan   = chan_sel;
      cur.view   = view_sel;
      cur.mask   = !sys_rst && raster_src.active &&
                   window_hit(pixel_in, chan_sel, lower_nibble, upper_nibble);
      cur.locked = tb_locked;
      cur.cx     = tb_cx;
      cur.cy     = tb_cy;

      if (!sys_rst) begin
        if (cur.mask) begin
          sx = sx + int'(raster_src.hcount);
          sy = sy + int'(raster_src.vcount);
          cnt = cnt + 1;
        end
        if (raster_src.new_frame) begin
          if (pending)
            note_problem(T_COM, "no com_valid pulse arrived within the frame");
          if (cnt == 0)
            empty_seen++;
          else begin
            exp_x = sx / cnt; // floor of the mean
            exp_y = sy / cnt;
          end
          pending = (cnt != 0);
          sx = 0;
          sy = 0;
          cnt = 0;
          frame_idx++;
        end
      end

      if (cyc >= RESET_CYCLES + 2) begin
        check(T_DELAY, {7'b0, d2.raster}, {7'b0, raster_out});
        exp_rgb = expected_rgb(d2, d1.view); // view is sampled one stage later
        if (d1.view == tracker_pkg::VIEW_CAMERA) begin
          rgb_id = T_CROSS;
          if (d2.raster.active && on_cross(d2))
            cross_seen++;
        end else if (d2.chan == tracker_pkg::CHAN_RED)
          rgb_id = T_RED;
        else if (d2.chan == tracker_pkg::CHAN_GREEN)
          rgb_id = T_GREEN;
        else
          rgb_id = T_BLUE;
        check(rgb_id, {8'b0, exp_rgb}, {8'b0, rgb_out});
      end
      d2 = d1;
      d1 = cur;

      if (frame_idx >= N_FRAMES && !pending)
        run_over = 1'b1; // last centre of mass is in
      if (!run_over && cyc >= TIMEOUT_CYCLES) begin
        $display("timeout at cycle %0d before the last centre of mass arrived", cyc);
        timed_out = 1'b1;
        run_over = 1'b1;
      end
    end
  end

  initial begin
    sys_rst = 1'b1;
    pixel_in = '0;
    chan_sel = tracker_pkg::CHAN_RED;
    lower_nibble = 4'hE;
    upper_nibble = 4'hF;
    view_sel = tracker_pkg::VIEW_MASK;
    for (int i = 0; i < N_TESTS; i++) begin
      checks[i] = 0;
      errs[i] = 0;
      first_is_value[i] = 1'b0;
    end
    wait (run_over);
    for (int i = 0; i < N_TESTS; i++)
      report_test(i);
    $display("%0d tests passed, %0d tests failed, %0d failed checks", passed_tests,
             failed_tests, bad_checks);
    if (failed_tests == 0 && !timed_out)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== hdl/tracker_top.sv ====
`timescale 1ns/1ps

module tracker_top #(
  parameter logic [10:0] H_ACTIVE = 11'd1280,
  parameter logic [10:0] H_FRONT  = 11'd110,
  parameter logic [10:0] H_SYNC   = 11'd40,
  parameter logic [10:0] H_BACK   = 11'd220,
  parameter logic [9:0]  V_ACTIVE = 10'd720,
  parameter logic [9:0]  V_FRONT  = 10'd5,
  parameter logic [9:0]  V_SYNC   = 10'd5,
  parameter logic [9:0]  V_BACK   = 10'd20
) (
  input  logic                   clk_pixel,
  input  logic                   sys_rst,
  input  tracker_pkg::pixel565_t pixel_in,  // pixel for raster_src, same cycle
  input  tracker_pkg::chan_e     chan_sel,
  input  logic [3:0]             lower_nibble,
  input  logic [3:0]             upper_nibble,
  input  tracker_pkg::view_e     view_sel,
  output tracker_pkg::raster_t   raster_src, // position the camera must supply now
  output tracker_pkg::raster_t   raster_out, // raster_src two cycles later
  output tracker_pkg::rgb888_t   rgb_out,
  output logic [10:0]            com_x,
  output logic [9:0]             com_y,
  output logic                   com_valid
);

  localparam int CNT_W   = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, 1);
  localparam int SUM_X_W = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, H_ACTIVE);
  localparam int SUM_Y_W = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, V_ACTIVE);

  // first stage, after the threshold register
  tracker_pkg::raster_t   raster_m;
  tracker_pkg::pixel565_t pixel_m;
  logic                   mask;

  // frame totals
  logic [SUM_X_W-1:0] sum_x;
  logic [SUM_Y_W-1:0] sum_y;
  logic [CNT_W-1:0]   count;
  logic               totals_valid;

  video_timing #(
    .H_ACTIVE(H_ACTIVE),
    .H_FRONT (H_FRONT),
    .H_SYNC  (H_SYNC),
    .H_BACK  (H_BACK),
    .V_ACTIVE(V_ACTIVE),
    .V_FRONT (V_FRONT),
    .V_SYNC  (V_SYNC),
    .V_BACK  (V_BACK)
  ) video_timing_inst (
    .clk_pixel(clk_pixel),
    .sys_rst  (sys_rst),
    .raster   (raster_src)
  );

  mask_threshold mask_threshold_inst (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .raster_in   (raster_src),
    .pixel_in    (pixel_in),
    .chan_sel    (chan_sel),
    .lower_nibble(lower_nibble),
    .upper_nibble(upper_nibble),
    .mask        (mask),
    .raster_m    (raster_m),
    .pixel_m     (pixel_m)
  );

  com_accumulator #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
  ) com_accumulator_inst (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .raster_m    (raster_m),
    .mask        (mask),
    .sum_x       (sum_x),
    .sum_y       (sum_y),
    .count       (count),
    .totals_valid(totals_valid)
  );

  com_divider #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
  ) com_divider_inst (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .sum_x       (sum_x),
    .sum_y       (sum_y),
    .count       (count),
    .totals_valid(totals_valid),
    .com_x       (com_x),
    .com_y       (com_y),
    .com_valid   (com_valid)
  );

  overlay_mixer overlay_mixer_inst (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .raster_m  (raster_m),
    .mask      (mask),
    .pixel_m   (pixel_m),
    .view_sel  (view_sel),
    .com_x     (com_x),
    .com_y     (com_y),
    .com_valid (com_valid),
    .rgb_out   (rgb_out),
    .raster_out(raster_out)
  );

endmodule

// ==== hdl/overlay_mixer.sv ====
`timescale 1ns/1ps

module overlay_mixer (
  input  logic                   clk_pixel,
  input  logic                   sys_rst,
  input  tracker_pkg::raster_t   raster_m,
  input  logic                   mask,
  input  tracker_pkg::pixel565_t pixel_m,
  input  tracker_pkg::view_e     view_sel,
  input  logic [10:0]            com_x,
  input  logic [9:0]             com_y,
  input  logic                   com_valid,
  output tracker_pkg::rgb888_t   rgb_out,
  output tracker_pkg::raster_t   raster_out
);

  logic                 locked;     // a centre of mass has been seen
  logic [10:0]          cross_x;    // crosshair column
  logic [9:0]           cross_y;    // crosshair row
  logic                 on_cross;
  tracker_pkg::rgb888_t pixel_next;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst)
      locked <= 1'b0;
    else if (com_valid)
      locked <= 1'b1; // stays set
  end

  // last published point
  always_ff @(posedge clk_pixel) begin
    if (com_valid) begin
      cross_x <= com_x;
      cross_y <= com_y;
    end
  end

  always_comb begin
    on_cross = locked &&
               ((raster_m.hcount == cross_x) || (raster_m.vcount == cross_y));
    if (!raster_m.active)
      pixel_next = '0; // blanking is black
    else if (on_cross)
      pixel_next = '{8'hF2, 8'hF2, 8'hF2};
    else if (view_sel == tracker_pkg::VIEW_CAMERA)
      pixel_next = tracker_pkg::widen565(pixel_m);
    else
      pixel_next = mask ? 24'hFF_FFFF : 24'h00_0000; // white where masked
  end

  // second pipeline stage; raster kept in step with the colour
  always_ff @(posedge clk_pixel) begin
    rgb_out    <= pixel_next;
    raster_out <= raster_m;
  end

endmodule

// ==== hdl/com_divider.sv ====
`timescale 1ns/1ps

module com_divider #(
  parameter logic [10:0] H_ACTIVE = 11'd1280,
  parameter logic [9:0]  V_ACTIVE = 10'd720,
  localparam int CNT_W   = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, 1),
  localparam int SUM_X_W = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, H_ACTIVE),
  localparam int SUM_Y_W = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, V_ACTIVE)
) (
  input  logic               clk_pixel,
  input  logic               sys_rst,
  input  logic [SUM_X_W-1:0] sum_x,
  input  logic [SUM_Y_W-1:0] sum_y,
  input  logic [CNT_W-1:0]   count,
  input  logic               totals_valid,
  output logic [10:0]        com_x,
  output logic [9:0]         com_y,
  output logic               com_valid
);

  // one dividend width for both passes, never narrower than com_x
  localparam int DW_RAW = (SUM_X_W > SUM_Y_W) ? SUM_X_W : SUM_Y_W;
  localparam int DW     = (DW_RAW < 11) ? 11 : DW_RAW;
  localparam int BW     = $clog2(DW);

  tracker_pkg::div_state_e state;

  logic [BW-1:0]    bit_cnt;   // quotient bits left in this pass, minus one
  logic [DW-1:0]    dvd;       // dividend shifts out the top, quotient shifts in below
  logic [CNT_W-1:0] divisor;   // mask pixel count of the frame
  logic [CNT_W-1:0] rem;       // partial remainder
  logic [10:0]      quot_x;    // x result parked while y runs
  logic [CNT_W:0]   rem_shift; // remainder with the next dividend bit brought down
  logic             q_bit;
  logic [CNT_W-1:0] rem_next;
  logic [DW-1:0]    dvd_next;

  // restoring step, one quotient bit
  always_comb begin
    rem_shift = {rem, dvd[DW-1]};
    q_bit     = (rem_shift >= {1'b0, divisor});
    rem_next  = q_bit ? CNT_W'(rem_shift - {1'b0, divisor}) : rem_shift[CNT_W-1:0];
    dvd_next  = {dvd[DW-2:0], q_bit};
  end

  // control and results
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state     <= tracker_pkg::DIV_IDLE;
      bit_cnt   <= '0;
      com_x     <= '0;
      com_y     <= '0;
      com_valid <= 1'b0;
    end else begin
      com_valid <= 1'b0;
      case (state)
        tracker_pkg::DIV_IDLE: begin
          if (totals_valid && (count != '0)) begin // empty frame keeps the old point
            bit_cnt <= BW'(DW - 1);
            state   <= tracker_pkg::DIV_X;
          end
        end
        tracker_pkg::DIV_X: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bit_cnt <= BW'(DW - 1); // rearm for y
            state   <= tracker_pkg::DIV_Y;
          end
        end
        tracker_pkg::DIV_Y: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0)
            state <= tracker_pkg::DIV_DONE;
        end
        tracker_pkg::DIV_DONE: begin
          com_x     <= quot_x;
          com_y     <= dvd[9:0]; // y quotient sits in the low bits now
          com_valid <= 1'b1;
          state     <= tracker_pkg::DIV_IDLE;
        end
        default: state <= tracker_pkg::DIV_IDLE;
      endcase
    end
  end

  // datapath, steered by the state
  always_ff @(posedge clk_pixel) begin
    case (state)
      tracker_pkg::DIV_IDLE: begin
        divisor <= count;
        dvd     <= DW'(sum_x);
        rem     <= '0;
      end
      tracker_pkg::DIV_X: begin
        if (bit_cnt == '0) begin
          quot_x <= dvd_next[10:0]; // floor of the mean column
          dvd    <= DW'(sum_y);     // totals hold until the next frame edge
          rem    <= '0;
        end else begin
          dvd <= dvd_next;
          rem <= rem_next;
        end
      end
      tracker_pkg::DIV_Y: begin
        dvd <= dvd_next;
        rem <= rem_next;
      end
      default: ;
    endcase
  end

endmodule

// ==== hdl/com_accumulator.sv ====
`timescale 1ns/1ps

module com_accumulator #(
  parameter logic [10:0] H_ACTIVE = 11'd1280,
  parameter logic [9:0]  V_ACTIVE = 10'd720,
  localparam int CNT_W   = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, 1),
  localparam int SUM_X_W = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, H_ACTIVE),
  localparam int SUM_Y_W = tracker_pkg::acc_width(H_ACTIVE, V_ACTIVE, V_ACTIVE)
) (
  input  logic                 clk_pixel,
  input  logic                 sys_rst,
  input  tracker_pkg::raster_t raster_m,
  input  logic                 mask,
  output logic [SUM_X_W-1:0]   sum_x,
  output logic [SUM_Y_W-1:0]   sum_y,
  output logic [CNT_W-1:0]     count,
  output logic                 totals_valid
);

  // the three per-frame totals, kept together
  typedef struct packed {
    logic [SUM_X_W-1:0] sum_x;
    logic [SUM_Y_W-1:0] sum_y;
    logic [CNT_W-1:0]   count;
  } frame_totals_t;

  frame_totals_t running; // sums for the frame in progress
  frame_totals_t totals;  // last complete frame
  logic          hit;     // visible mask pixel

  assign hit = raster_m.active && mask;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      running      <= '0;
      totals_valid <= 1'b0;
    end else begin
      totals_valid <= raster_m.new_frame; // lines up with the totals copy
      if (raster_m.new_frame) begin
        running <= '0; // start the next frame
      end else if (hit) begin
        running.sum_x <= running.sum_x + SUM_X_W'(raster_m.hcount);
        running.sum_y <= running.sum_y + SUM_Y_W'(raster_m.vcount);
        running.count <= running.count + 1'b1;
      end
    end
  end

  // frame boundary snapshot, held steady until the next boundary
  always_ff @(posedge clk_pixel) begin
    if (raster_m.new_frame)
      totals <= running;
  end

  assign sum_x = totals.sum_x;
  assign sum_y = totals.sum_y;
  assign count = totals.count;

endmodule

// ==== hdl/mask_threshold.sv ====
`timescale 1ns/1ps

module mask_threshold (
  input  logic                   clk_pixel,
  input  logic                   sys_rst,
  input  tracker_pkg::raster_t   raster_in,
  input  tracker_pkg::pixel565_t pixel_in,
  input  tracker_pkg::chan_e     chan_sel,
  input  logic [3:0]             lower_nibble,
  input  logic [3:0]             upper_nibble,
  output logic                   mask,
  output tracker_pkg::raster_t   raster_m,
  output tracker_pkg::pixel565_t pixel_m
);

  tracker_pkg::rgb888_t wide; // camera pixel at 8 bits per channel
  logic [7:0] channel;        // the selected channel
  logic [7:0] lower_bound;
  logic [7:0] upper_bound;
  logic       chan_ok;        // low for the unused channel code
  logic       in_window;

  assign wide        = tracker_pkg::widen565(pixel_in);
  assign lower_bound = {lower_nibble, 4'b0000};
  assign upper_bound = {upper_nibble, 4'b0000};

  always_comb begin
    chan_ok = 1'b1;
    case (chan_sel)
      tracker_pkg::CHAN_RED:   channel = wide.red;
      tracker_pkg::CHAN_GREEN: channel = wide.green;
      tracker_pkg::CHAN_BLUE:  channel = wide.blue;
      default: begin
        channel = 8'd0;
        chan_ok = 1'b0; // fourth code never matches
      end
    endcase
  end

  // both bounds inclusive; blanking never masks
  assign in_window = chan_ok && raster_in.active &&
                     (channel >= lower_bound) && (channel <= upper_bound);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst)
      mask <= 1'b0;
    else
      mask <= in_window;
  end

  // raster and pixel ride along with the mask bit
  always_ff @(posedge clk_pixel) begin
    raster_m <= raster_in;
    pixel_m  <= pixel_in;
  end

endmodule

// ==== hdl/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
  parameter logic [10:0] H_ACTIVE = 11'd1280,
  parameter logic [10:0] H_FRONT  = 11'd110,
  parameter logic [10:0] H_SYNC   = 11'd40,
  parameter logic [10:0] H_BACK   = 11'd220,
  parameter logic [9:0]  V_ACTIVE = 10'd720,
  parameter logic [9:0]  V_FRONT  = 10'd5,
  parameter logic [9:0]  V_SYNC   = 10'd5,
  parameter logic [9:0]  V_BACK   = 10'd20
) (
  input  logic                 clk_pixel,
  input  logic                 sys_rst,
  output tracker_pkg::raster_t raster
);

  // interval edges along the line
  localparam logic [10:0] H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam logic [10:0] H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam logic [10:0] H_TOTAL      = H_SYNC_END + H_BACK;
  // and down the frame, in whole lines
  localparam logic [9:0]  V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam logic [9:0]  V_SYNC_END   = V_SYNC_START + V_SYNC;
  localparam logic [9:0]  V_TOTAL      = V_SYNC_END + V_BACK;

  logic [10:0] hcount;
  logic [9:0]  vcount;
  logic        h_last; // last column of the line
  logic        v_last; // last line of the frame

  assign h_last = (hcount == H_TOTAL - 11'd1);
  assign v_last = (vcount == V_TOTAL - 10'd1);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      hcount <= '0;
      vcount <= '0;
    end else if (h_last) begin
      hcount <= '0; // wrap line
      vcount <= v_last ? '0 : vcount + 10'd1;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // flags decode straight off the counters, so they follow the counts in the same cycle
  always_comb begin
    raster.hcount    = hcount;
    raster.vcount    = vcount;
    raster.active    = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    raster.hsync     = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);
    raster.vsync     = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);
    raster.new_frame = (hcount == H_ACTIVE) && (vcount == V_ACTIVE); // once per frame
  end

endmodule

// ==== hdl/tracker_pkg.sv ====
package tracker_pkg;

  // camera pixel as it arrives, rgb 5-6-5
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } pixel565_t;

  // display pixel, 8 bits per channel
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // one raster position plus its flags
  typedef struct packed {
    logic [10:0] hcount; // column
    logic [9:0]  vcount; // row
    logic        hsync;  // active high
    logic        vsync;  // active high
    logic        active; // level, inside the visible area
    logic        new_frame; // one cycle at the first blanking position after the last pixel
  } raster_t;

  // channel fed to the threshold; code 3 is unused and masks everything out
  typedef enum logic [1:0] {
    CHAN_RED,
    CHAN_GREEN,
    CHAN_BLUE
  } chan_e;

  // background behind the crosshair
  typedef enum logic {
    VIEW_CAMERA,
    VIEW_MASK
  } view_e;

  // serial divider states
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_X,
    DIV_Y,
    DIV_DONE
  } div_state_e;

  // 565 to 888, each field left-justified and zero-padded
  function automatic rgb888_t widen565(input pixel565_t pix);
    rgb888_t wide;
    wide.red   = {pix.red, 3'b000};
    wide.green = {pix.green, 2'b00};
    wide.blue  = {pix.blue, 3'b000};
    return wide;
  endfunction

  // bits to hold a*b*c, used to size per-frame sums and counts
  function automatic int acc_width(input int a, input int b, input int c);
    return $clog2(a * b * c + 1);
  endfunction

endpackage
